// File: icmp_echo.f
+incdir+verification
hdl/icmp_pkg.sv
hdl/icmp_payload_fifo.sv
hdl/icmp_echo_rx.sv
hdl/icmp_echo_tx.sv
hdl/icmp_echo.sv
verification/icmp_echo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ICMP echo testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing -Wno-fatal --top-module icmp_echo_tb \
  -f icmp_echo.f -o icmp_echo_sim > build.log 2>&1 \
  || { cat build.log; echo "Build step failed"; exit 1; }

./obj_dir/icmp_echo_sim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log

grep -q "Regression passed" sim.log && exit 0 || exit 1

// File: verification/icmp_echo_tests.svh
task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    val_errs++;
  end
endtask

task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    val_errs++;
  end
endtask

task automatic check_ip(input string name, input ipv4_addr_t got, input ipv4_addr_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    val_errs++;
  end
endtask

task automatic check_mac(input string name, input mac_addr_t got, input mac_addr_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    val_errs++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    val_errs++;
  end
endtask

// Request checksum plus 0x0800 with the carry folded back
function automatic logic [15:0] expected_chsum(input logic [15:0] c);
  int s;
  s = int'(c) + 'h0800;
  if (s > 'hFFFF) begin
    s = s - 'hFFFF;  // One's complement wrap
  end
  return 16'(s);
endfunction

task automatic new_request(input int n);
  int i;
  ping_src_ip  = $random(seed);
  ping_ip_id   = 16'($random(seed));
  ping_mac_src = {16'($random(seed)), 32'($random(seed))};
  ping_mac_dst = {16'($random(seed)), 32'($random(seed))};
  ping_chsum   = 16'($random(seed));
  ping_id      = 16'($random(seed));
  ping_seq     = 16'($random(seed));
  pay_q.delete();
  for (i = 0; i < n; i++) begin
    pay_q.push_back(8'($random(seed)));
  end
endtask

task automatic send_frame(input logic [7:0] proto, input logic [7:0] icmp_type,
                          input int len_delta, input int err_at);
  icmp_hdr_u  hdr;
  logic [7:0] frame [$];
  int         i;
  int         n;
  hdr.fields.icmp_type  = icmp_type;
  hdr.fields.icmp_code  = 8'd0;
  hdr.fields.icmp_chsum = ping_chsum;
  hdr.fields.icmp_id    = ping_id;
  hdr.fields.icmp_seq   = ping_seq;
  for (i = 0; i < icmp_hdr_len; i++) begin
    frame.push_back(hdr.bytes[icmp_hdr_len-1-i]);  // Type byte goes first
  end
  for (i = 0; i < pay_q.size(); i++) begin
    frame.push_back(pay_q[i]);
  end
  n = frame.size();
  for (i = 0; i < n; i++) begin
    @(posedge clk);
    in_dat <= frame[i];
    in_val <= 1'b1;
    in_sof <= (i == 0);
    in_eof <= (i == n - 1);
    in_err <= (i == err_at);
    if (i == 0) begin
      in_proto     <= proto;
      in_src_ip    <= ping_src_ip;
      in_dst_ip    <= local_ip;
      in_ip_id     <= ping_ip_id;
      in_ip_length <= 16'(ipv4_hdr_len + n + len_delta);
      in_mac_src   <= ping_mac_src;
      in_mac_dst   <= ping_mac_dst;
    end
  end
  @(negedge clk);
  eof_cyc = cyc;
  @(posedge clk);
  in_val <= 1'b0;
  in_sof <= 1'b0;
  in_eof <= 1'b0;
  in_err <= 1'b0;
endtask

task automatic wait_rdy(output bit seen);
  int waited;
  seen   = 1'b0;
  waited = 0;
  while (!seen && waited < rdy_window) begin
    @(negedge clk);
    waited++;
    if (out_rdy) begin
      seen          = 1'b1;
      rdy_cyc       = cyc;
      cap_src_ip    = out_src_ip;
      cap_dst_ip    = out_dst_ip;
      cap_ip_id     = out_ip_id;
      cap_ip_length = out_ip_length;
      cap_proto     = out_proto;
      cap_mac_src   = out_mac_src;
      cap_mac_dst   = out_mac_dst;
    end
  end
  if (!seen) begin
    $display("No out_rdy within %0d cycles of in_eof, the reply is missing", rdy_window);
    proto_errs++;
  end
endtask

task automatic grant_and_collect(input int delay, input int n_exp);
  int i;
  bit done;
  got_q.delete();
  for (i = 0; i < delay; i++) begin
    @(negedge clk);
    check_bit("out_rdy before grant", out_rdy, 1'b1);  // Held until out_req
  end
  @(posedge clk);
  out_req <= 1'b1;
  @(negedge clk);
  grant_cyc = cyc;
  check_bit("out_rdy at grant", out_rdy, 1'b1);
  @(posedge clk);
  out_req <= 1'b0;
  @(negedge clk);
  check_bit("out_sof", out_sof, 1'b1);
  done = 1'b0;
  while (!done && (cyc - grant_cyc) <= n_exp + 4) begin
    check_bit("out_val", out_val, 1'b1);  // No gaps once started
    if (out_val) begin
      got_q.push_back(out_dat);
    end
    if (out_eof) begin
      done = 1'b1;
      check_word("grant to out_eof cycles", 16'(cyc - grant_cyc), 16'(n_exp));
    end else begin
      @(negedge clk);
    end
  end
  if (!done) begin
    $display("Reply of %0d bytes never ended with out_eof", n_exp);
    proto_errs++;
  end
endtask

task automatic verify_reply(input int n_pay);
  icmp_hdr_u rsp;
  int        i;
  check_word("reply length", 16'(got_q.size()), 16'(icmp_hdr_len + n_pay));
  if (got_q.size() != icmp_hdr_len + n_pay) begin
    return;
  end
  for (i = 0; i < icmp_hdr_len; i++) begin
    rsp.bytes[icmp_hdr_len-1-i] = got_q[i];
  end
  check_byte("icmp_type", rsp.fields.icmp_type, 8'd0);
  check_byte("icmp_code", rsp.fields.icmp_code, 8'd0);
  check_word("icmp_chsum", rsp.fields.icmp_chsum, expected_chsum(ping_chsum));
  check_word("icmp_id", rsp.fields.icmp_id, ping_id);
  check_word("icmp_seq", rsp.fields.icmp_seq, ping_seq);
  for (i = 0; i < n_pay; i++) begin
    check_byte($sformatf("payload[%0d]", i), got_q[icmp_hdr_len+i], pay_q[i]);
  end
  check_ip("out_src_ip", cap_src_ip, local_ip);
  check_ip("out_dst_ip", cap_dst_ip, ping_src_ip);
  check_word("out_ip_id", cap_ip_id, ping_ip_id);
  check_word("out_ip_length", cap_ip_length, 16'(ipv4_hdr_len + icmp_hdr_len + n_pay));
  check_byte("out_proto", cap_proto, 8'd1);
  check_mac("out_mac_src", cap_mac_src, ping_mac_dst);
  check_mac("out_mac_dst", cap_mac_dst, ping_mac_src);
endtask

task automatic answer_request(input int delay, input int n_pay);
  bit seen;
  wait_rdy(seen);
  if (seen) begin
    check_word("in_eof to out_rdy cycles", 16'(rdy_cyc - eof_cyc), 16'd2);
    grant_and_collect(delay, icmp_hdr_len + n_pay);
    verify_reply(n_pay);
  end
endtask

task automatic expect_no_reply(input string what);
  int i;
  bit hit;
  hit = 1'b0;
  for (i = 0; i < drop_window; i++) begin
    @(negedge clk);
    if (out_rdy || out_val) begin
      hit = 1'b1;
    end
  end
  if (hit) begin
    $display("A reply was started for a frame that must be dropped (%s)", what);
    proto_errs++;
  end
endtask

task automatic test_reset_state();
  @(negedge clk);
  check_bit("out_rdy after reset", out_rdy, 1'b0);
  check_bit("out_val after reset", out_val, 1'b0);
  check_bit("out_sof after reset", out_sof, 1'b0);
  check_bit("out_eof after reset", out_eof, 1'b0);
endtask

task automatic test_echo_basic();
  int k;
  int n;
  for (k = 0; k < 3; k++) begin
    n = 1 + int'($unsigned($random(seed)) % 32);
    new_request(n);
    if (k == 2) begin
      ping_chsum = 16'hFA5C;  // Sum overflows 16 bits
    end
    send_frame(proto_icmp, icmp_echo_request, 0, -1);
    answer_request(0, n);
  end
endtask

task automatic test_dropped();
  new_request(8);
  send_frame(proto_icmp, 8'd0, 0, -1);
  expect_no_reply("echo reply type");
  new_request(8);
  send_frame(proto_icmp, 8'd13, 0, -1);
  expect_no_reply("timestamp type");
  new_request(8);
  send_frame(8'd17, icmp_echo_request, 0, -1);
  expect_no_reply("UDP protocol");
endtask

task automatic test_faulty();
  new_request(12);
  send_frame(proto_icmp, icmp_echo_request, 2, -1);
  expect_no_reply("length mismatch");
  new_request(5);
  send_frame(proto_icmp, icmp_echo_request, 0, -1);
  answer_request(0, 5);
  new_request(12);
  send_frame(proto_icmp, icmp_echo_request, 0, 10);  // Error on a payload byte
  expect_no_reply("in_err");
  new_request(7);
  send_frame(proto_icmp, icmp_echo_request, 0, -1);
  answer_request(3, 7);
endtask

task automatic test_backpressure();
  logic [7:0]  first_pay [$];
  logic [15:0] first_seq;
  int          k;
  int          n;
  int          delay;
  bit          seen;
  for (k = 0; k < 2; k++) begin
    n     = 1 + int'($unsigned($random(seed)) % 32);
    delay = int'($unsigned($random(seed)) % (max_grant_delay + 1));
    new_request(n);
    send_frame(proto_icmp, icmp_echo_request, 0, -1);
    answer_request(delay, n);
  end
  // Second ping arrives while the first waits for its grant
  n = 16;
  new_request(n);
  send_frame(proto_icmp, icmp_echo_request, 0, -1);
  wait_rdy(seen);
  first_pay = pay_q;
  first_seq = ping_seq;
  ping_seq  = first_seq + 16'd1;
  for (k = 0; k < n; k++) begin
    pay_q[k] = ~pay_q[k];
  end
  send_frame(proto_icmp, icmp_echo_request, 0, -1);
  pay_q    = first_pay;
  ping_seq = first_seq;
  if (seen) begin
    delay = int'($unsigned($random(seed)) % (max_grant_delay + 1));
    grant_and_collect(delay, icmp_hdr_len + n);
    verify_reply(n);
  end
  expect_no_reply("request sent while busy");
endtask

task automatic test_size_limit();
  new_request(payload_depth);
  send_frame(proto_icmp, icmp_echo_request, 0, -1);
  answer_request(0, payload_depth);
  new_request(payload_depth + 1);
  send_frame(proto_icmp, icmp_echo_request, 0, -1);
  expect_no_reply("payload over FIFO depth");
endtask

// File: verification/icmp_echo_tb.sv
`timescale 1ns/1ps

module icmp_echo_tb import icmp_pkg::*;;

  localparam int payload_depth   = 64;
  localparam int cnt_width       = 16;
  localparam int rdy_window      = 8;   // Cycles allowed from in_eof to out_rdy
  localparam int drop_window     = 16;
  localparam int max_grant_delay = 20;
  localparam int n_frames        = 16;  // Frames sent over all tests
  localparam int timeout_cycles  =
    n_frames * (2 * (icmp_hdr_len + payload_depth + 1) + max_grant_delay + drop_window) + 100;

  logic        clk = 1'b0;
  logic        fsm_rst;
  ipv4_addr_t  local_ip;
  logic [7:0]  in_dat;
  logic        in_val;
  logic        in_sof;
  logic        in_eof;
  logic        in_err;
  logic [7:0]  in_proto;
  ipv4_addr_t  in_src_ip;
  ipv4_addr_t  in_dst_ip;
  logic [15:0] in_ip_id;
  logic [15:0] in_ip_length;
  mac_addr_t   in_mac_src;
  mac_addr_t   in_mac_dst;
  logic        out_req;
  logic [7:0]  out_dat;
  logic        out_val;
  logic        out_sof;
  logic        out_eof;
  logic        out_rdy;
  ipv4_addr_t  out_src_ip;
  ipv4_addr_t  out_dst_ip;
  logic [15:0] out_ip_id;
  logic [15:0] out_ip_length;
  logic [7:0]  out_proto;
  mac_addr_t   out_mac_src;
  mac_addr_t   out_mac_dst;

  int          seed = 77771;
  int          cyc = 0;
  int          val_errs = 0;
  int          proto_errs = 0;
  int          eof_cyc;
  int          rdy_cyc;
  int          grant_cyc;

  // Current ping request
  ipv4_addr_t  ping_src_ip;
  logic [15:0] ping_ip_id;
  mac_addr_t   ping_mac_src;
  mac_addr_t   ping_mac_dst;
  logic [15:0] ping_chsum;
  logic [15:0] ping_id;
  logic [15:0] ping_seq;
  logic [7:0]  pay_q [$];

  // Reply as seen on the output side
  logic [7:0]  got_q [$];
  ipv4_addr_t  cap_src_ip;
  ipv4_addr_t  cap_dst_ip;
  logic [15:0] cap_ip_id;
  logic [15:0] cap_ip_length;
  logic [7:0]  cap_proto;
  mac_addr_t   cap_mac_src;
  mac_addr_t   cap_mac_dst;

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  icmp_echo #(
    .payload_depth (payload_depth),
    .cnt_width     (cnt_width)
  ) u_icmp_echo (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .local_ip      (local_ip),
    .in_dat        (in_dat),
    .in_val        (in_val),
    .in_sof        (in_sof),
    .in_eof        (in_eof),
    .in_err        (in_err),
    .in_proto      (in_proto),
    .in_src_ip     (in_src_ip),
    .in_dst_ip     (in_dst_ip),
    .in_ip_id      (in_ip_id),
    .in_ip_length  (in_ip_length),
    .in_mac_src    (in_mac_src),
    .in_mac_dst    (in_mac_dst),
    .out_req       (out_req),
    .out_dat       (out_dat),
    .out_val       (out_val),
    .out_sof       (out_sof),
    .out_eof       (out_eof),
    .out_rdy       (out_rdy),
    .out_src_ip    (out_src_ip),
    .out_dst_ip    (out_dst_ip),
    .out_ip_id     (out_ip_id),
    .out_ip_length (out_ip_length),
    .out_proto     (out_proto),
    .out_mac_src   (out_mac_src),
    .out_mac_dst   (out_mac_dst)
  );

  `include "icmp_echo_tests.svh"

  initial begin
    fsm_rst      = 1'b1;
    local_ip     = 32'hC0A8_0A01;
    in_dat       = 8'h00;
    in_val       = 1'b0;
    in_sof       = 1'b0;
    in_eof       = 1'b0;
    in_err       = 1'b0;
    in_proto     = 8'h00;
    in_src_ip    = '0;
    in_dst_ip    = '0;
    in_ip_id     = '0;
    in_ip_length = '0;
    in_mac_src   = '0;
    in_mac_dst   = '0;
    out_req      = 1'b0;
    repeat (5) @(posedge clk);
    fsm_rst <= 1'b0;

    test_reset_state();
    test_echo_basic();
    test_dropped();
    test_faulty();
    test_backpressure();
    test_size_limit();

    repeat (4) @(posedge clk);
    $display("Summary: %0d value errors, %0d protocol errors", val_errs, proto_errs);
    if (val_errs + proto_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    wait (cyc >= timeout_cycles);
    $display("Run stopped after %0d cycles without finishing the tests", cyc);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: hdl/icmp_echo.sv
`timescale 1ns/1ps

module icmp_echo import icmp_pkg::*; #(
  parameter int payload_depth = 64,
  parameter int cnt_width     = 16
) (
  input  logic        clk,
  input  logic        fsm_rst,
  input  ipv4_addr_t  local_ip,
  input  logic [7:0]  in_dat,
  input  logic        in_val,
  input  logic        in_sof,
  input  logic        in_eof,
  input  logic        in_err,
  input  logic [7:0]  in_proto,
  input  ipv4_addr_t  in_src_ip,
  input  ipv4_addr_t  in_dst_ip,
  input  logic [15:0] in_ip_id,
  input  logic [15:0] in_ip_length,
  input  mac_addr_t   in_mac_src,
  input  mac_addr_t   in_mac_dst,
  input  logic        out_req,
  output logic [7:0]  out_dat,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof,
  output logic        out_rdy,
  output ipv4_addr_t  out_src_ip,
  output ipv4_addr_t  out_dst_ip,
  output logic [15:0] out_ip_id,
  output logic [15:0] out_ip_length,
  output logic [7:0]  out_proto,
  output mac_addr_t   out_mac_src,
  output mac_addr_t   out_mac_dst
);

  logic        wr_en;
  logic [7:0]  wr_dat;
  logic        flush;
  logic        overflow;
  logic        rd_en;
  logic [7:0]  rd_dat;
  logic        empty;
  logic        busy;
  logic        req_val;
  icmp_hdr_u   req_hdr;
  ipv4_addr_t  req_src_ip;
  logic [15:0] req_ip_id;
  logic [15:0] req_ip_length;
  mac_addr_t   req_mac_src;
  mac_addr_t   req_mac_dst;

  icmp_echo_rx #(
    .cnt_width (cnt_width)
  ) u_rx (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .in_dat        (in_dat),
    .in_val        (in_val),
    .in_sof        (in_sof),
    .in_eof        (in_eof),
    .in_err        (in_err),
    .in_proto      (in_proto),
    .in_src_ip     (in_src_ip),
    .in_ip_id      (in_ip_id),
    .in_ip_length  (in_ip_length),
    .in_mac_src    (in_mac_src),
    .in_mac_dst    (in_mac_dst),
    .busy          (busy),
    .overflow      (overflow),
    .wr_en         (wr_en),
    .wr_dat        (wr_dat),
    .flush         (flush),
    .req_val       (req_val),
    .req_hdr       (req_hdr),
    .req_src_ip    (req_src_ip),
    .req_ip_id     (req_ip_id),
    .req_ip_length (req_ip_length),
    .req_mac_src   (req_mac_src),
    .req_mac_dst   (req_mac_dst)
  );

  icmp_payload_fifo #(
    .payload_depth (payload_depth)
  ) u_fifo (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .flush    (flush),
    .wr_en    (wr_en),
    .wr_dat   (wr_dat),
    .rd_en    (rd_en),
    .rd_dat   (rd_dat),
    .empty    (empty),
    .overflow (overflow)
  );

  icmp_echo_tx #(
    .cnt_width (cnt_width)
  ) u_tx (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .local_ip      (local_ip),
    .req_val       (req_val),
    .req_hdr       (req_hdr),
    .req_src_ip    (req_src_ip),
    .req_ip_id     (req_ip_id),
    .req_ip_length (req_ip_length),
    .req_mac_src   (req_mac_src),
    .req_mac_dst   (req_mac_dst),
    .rd_dat        (rd_dat),
    .empty         (empty),
    .out_req       (out_req),
    .rd_en         (rd_en),
    .busy          (busy),
    .out_dat       (out_dat),
    .out_val       (out_val),
    .out_sof       (out_sof),
    .out_eof       (out_eof),
    .out_rdy       (out_rdy),
    .out_src_ip    (out_src_ip),
    .out_dst_ip    (out_dst_ip),
    .out_ip_id     (out_ip_id),
    .out_ip_length (out_ip_length),
    .out_proto     (out_proto),
    .out_mac_src   (out_mac_src),
    .out_mac_dst   (out_mac_dst)
  );

endmodule

// File: hdl/icmp_echo_tx.sv
`timescale 1ns/1ps

module icmp_echo_tx import icmp_pkg::*; #(
  parameter int cnt_width = 16
) (
  input  logic        clk,
  input  logic        fsm_rst,
  input  ipv4_addr_t  local_ip,
  input  logic        req_val,
  input  icmp_hdr_u   req_hdr,
  input  ipv4_addr_t  req_src_ip,
  input  logic [15:0] req_ip_id,
  input  logic [15:0] req_ip_length,
  input  mac_addr_t   req_mac_src,
  input  mac_addr_t   req_mac_dst,
  input  logic [7:0]  rd_dat,
  input  logic        empty,
  input  logic        out_req,
  output logic        rd_en,
  output logic        busy,
  output logic [7:0]  out_dat,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof,
  output logic        out_rdy,
  output ipv4_addr_t  out_src_ip,
  output ipv4_addr_t  out_dst_ip,
  output logic [15:0] out_ip_id,
  output logic [15:0] out_ip_length,
  output logic [7:0]  out_proto,
  output mac_addr_t   out_mac_src,
  output mac_addr_t   out_mac_dst
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wait = 2'd1;  // out_rdy up, waiting for out_req
  localparam logic [1:0] st_send = 2'd2;

  logic [1:0]           state;
  logic                 busy_q;
  logic                 grant;
  logic                 emit;
  logic                 emit_hdr;
  logic [3:0]           hdr_cnt;  // Header bytes already sent
  logic [cnt_width-1:0] remain;   // Reply bytes still to send
  logic [16:0]          chsum_sum;
  logic [15:0]          chsum_reply;
  icmp_hdr_u            tx_hdr;

  assign chsum_sum   = {1'b0, req_hdr.fields.icmp_chsum} + {1'b0, icmp_chsum_adj};
  assign chsum_reply = chsum_sum[15:0] + 16'(chsum_sum[16]);  // End-around carry

  assign grant    = (state == st_wait) && out_rdy && out_req;
  assign emit     = grant || ((state == st_send) && (remain != '0));
  assign emit_hdr = emit && (hdr_cnt != 4'(icmp_hdr_len));
  assign rd_en    = emit && !emit_hdr && !empty;

  assign busy = busy_q || req_val;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= st_idle;
      busy_q  <= 1'b0;
      out_rdy <= 1'b0;
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
      hdr_cnt <= '0;
      remain  <= '0;
    end else begin
      out_val <= emit;
      out_sof <= grant;
      out_eof <= emit && (remain == cnt_width'(1));
      if (emit) begin
        remain <= remain - 1'b1;
        if (emit_hdr) begin
          hdr_cnt <= hdr_cnt + 1'b1;
        end
      end
      case (state)
        st_idle: begin
          if (req_val) begin
            remain  <= cnt_width'(req_ip_length - 16'(ipv4_hdr_len));
            hdr_cnt <= '0;
            out_rdy <= 1'b1;
            busy_q  <= 1'b1;
            state   <= st_wait;
          end
        end
        st_wait: begin
          if (grant) begin
            out_rdy <= 1'b0;
            state   <= st_send;
          end
        end
        st_send: begin
          if (remain == '0) begin  // Cycle after out_eof
            busy_q <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_idle) && req_val) begin
      tx_hdr.fields.icmp_type  <= icmp_echo_reply;
      tx_hdr.fields.icmp_code  <= 8'd0;
      tx_hdr.fields.icmp_chsum <= chsum_reply;
      tx_hdr.fields.icmp_id    <= req_hdr.fields.icmp_id;
      tx_hdr.fields.icmp_seq   <= req_hdr.fields.icmp_seq;
      out_src_ip    <= local_ip;
      out_dst_ip    <= req_src_ip;
      out_ip_id     <= req_ip_id;
      out_ip_length <= req_ip_length;
      out_proto     <= proto_icmp;
      out_mac_src   <= req_mac_dst;  // Swap
      out_mac_dst   <= req_mac_src;
    end else if (emit_hdr) begin
      tx_hdr.bytes <= {tx_hdr.bytes[icmp_hdr_len-2:0], 8'h00};
    end
    if (emit) begin
      out_dat <= emit_hdr ? tx_hdr.bytes[icmp_hdr_len-1] : rd_dat;
    end
  end

endmodule

// File: hdl/icmp_echo_rx.sv
`timescale 1ns/1ps

module icmp_echo_rx import icmp_pkg::*; #(
  parameter int cnt_width = 16
) (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic [7:0]  in_dat,
  input  logic        in_val,
  input  logic        in_sof,
  input  logic        in_eof,
  input  logic        in_err,
  input  logic [7:0]  in_proto,
  input  ipv4_addr_t  in_src_ip,
  input  logic [15:0] in_ip_id,
  input  logic [15:0] in_ip_length,
  input  mac_addr_t   in_mac_src,
  input  mac_addr_t   in_mac_dst,
  input  logic        busy,
  input  logic        overflow,
  output logic        wr_en,
  output logic [7:0]  wr_dat,
  output logic        flush,
  output logic        req_val,
  output icmp_hdr_u   req_hdr,
  output ipv4_addr_t  req_src_ip,
  output logic [15:0] req_ip_id,
  output logic [15:0] req_ip_length,
  output mac_addr_t   req_mac_src,
  output mac_addr_t   req_mac_dst
);

  logic                 rx_active;  // Inside a taken frame
  logic                 take;
  logic [cnt_width-1:0] idx;
  logic [cnt_width-1:0] byte_cnt;
  logic [cnt_width-1:0] exp_len;
  logic                 err_now;
  logic                 err_seen;
  logic                 len_ok;
  logic                 done_q;
  logic                 good_q;
  logic                 accept;
  icmp_hdr_u            hdr;

  // A new frame is only taken while the reply path is idle
  assign take    = in_val && (in_sof ? !busy : rx_active);
  assign idx     = in_sof ? '0 : byte_cnt;  // Position of the current byte
  assign err_now = in_err || (!in_sof && err_seen);

  assign exp_len = cnt_width'(in_ip_length - 16'(ipv4_hdr_len));
  assign len_ok  = (idx + 1'b1 == exp_len) && (idx >= icmp_hdr_len - 1);

  assign wr_en  = take && (idx >= icmp_hdr_len);  // Payload only
  assign wr_dat = in_dat;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx_active <= 1'b0;
      byte_cnt  <= '0;
      err_seen  <= 1'b0;
      done_q    <= 1'b0;
      good_q    <= 1'b0;
    end else begin
      done_q <= take && in_eof;
      good_q <= len_ok && !err_now && (in_proto == proto_icmp);
      if (take) begin
        rx_active <= !in_eof;
        byte_cnt  <= idx + 1'b1;
        err_seen  <= err_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && (idx < icmp_hdr_len)) begin
      hdr.bytes <= {hdr.bytes[icmp_hdr_len-2:0], in_dat};
    end
    if (take && in_sof) begin  // Fields are stable for the frame
      req_src_ip    <= in_src_ip;
      req_ip_id     <= in_ip_id;
      req_ip_length <= in_ip_length;
      req_mac_src   <= in_mac_src;
      req_mac_dst   <= in_mac_dst;
    end
  end

  // Overflow of the last byte is visible here, one cycle after in_eof
  assign accept = done_q && good_q && !overflow &&
                  (hdr.fields.icmp_type == icmp_echo_request);

  assign req_val = accept;
  assign req_hdr = hdr;
  assign flush   = done_q && !accept;  // Drop the buffered payload

endmodule

// File: hdl/icmp_payload_fifo.sv
`timescale 1ns/1ps

module icmp_payload_fifo #(
  parameter int payload_depth = 64
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       flush,
  input  logic       wr_en,
  input  logic [7:0] wr_dat,
  input  logic       rd_en,
  output logic [7:0] rd_dat,
  output logic       empty,
  output logic       overflow
);

  localparam int aw = $clog2(payload_depth);

  logic [7:0]  mem [payload_depth];
  logic [aw:0] wr_ptr;  // Extra bit tells full from empty
  logic [aw:0] rd_ptr;
  logic        full;

  assign empty  = (wr_ptr == rd_ptr);
  assign full   = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
  assign rd_dat = mem[rd_ptr[aw-1:0]];  // Fall-through read

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else if (flush) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) begin
        if (full) begin
          overflow <= 1'b1;  // Byte is lost
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (rd_en && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !full && !flush) begin
      mem[wr_ptr[aw-1:0]] <= wr_dat;
    end
  end

endmodule

// File: hdl/icmp_pkg.sv
package icmp_pkg;

  localparam int icmp_hdr_len = 8;   // Type, code, checksum, id, seq
  localparam int ipv4_hdr_len = 20;  // No options

  localparam logic [7:0] proto_icmp = 8'd1;

  localparam logic [7:0] icmp_echo_request = 8'd8;
  localparam logic [7:0] icmp_echo_reply   = 8'd0;

  // Type moves from 8 to 0 in the high byte of the first header word,
  // so the one's complement checksum grows by 0x0800
  localparam logic [15:0] icmp_chsum_adj = 16'h0800;

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [47:0] mac_addr_t;

  typedef struct packed {
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] icmp_chsum;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
  } icmp_fields_t;

  // Byte view for shifting, field view for decode and build
  typedef union packed {
    logic [icmp_hdr_len-1:0][7:0] bytes;   // bytes[7] is first on the wire
    icmp_fields_t                 fields;
  } icmp_hdr_u;

endpackage
